//--- decodePkg.sv
// Shared definitions for the decode stage of the 16-bit teaching processor
// Holds the opcode map, register file sizing and the bundles passed between blocks
package decodePkg;

   localparam int dataWidth    = 16;                   // Register and instruction width
   localparam int regAddrWidth = 3;                    // Eight general registers
   localparam int numRegs      = 1 << regAddrWidth;
   localparam int opWidth      = 5;                    // Opcode sits in instr[15:11]

   // Jump-and-link instructions deposit their return address here
   localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

   // Every instruction is one halfword, so the next PC is two bytes on
   localparam logic [dataWidth-1:0] instrBytes = 16'd2;

   // Opcode map, only the encodings that decode cares about
   localparam logic [opWidth-1:0] opHalt  = 5'b00000;
   localparam logic [opWidth-1:0] opJ     = 5'b00100;  // Jump with displacement
   localparam logic [opWidth-1:0] opJr    = 5'b00101;  // Jump to register plus immediate
   localparam logic [opWidth-1:0] opJal   = 5'b00110;  // Jump and link
   localparam logic [opWidth-1:0] opJalr  = 5'b00111;  // Jump register and link
   localparam logic [opWidth-1:0] opBeqz  = 5'b01100;  // Low two bits pick the condition
   localparam logic [opWidth-1:0] opBnez  = 5'b01101;
   localparam logic [opWidth-1:0] opBltz  = 5'b01110;
   localparam logic [opWidth-1:0] opBgez  = 5'b01111;
   localparam logic [opWidth-1:0] opLbi   = 5'b11000;  // Load byte immediate

   // Control bundle produced by controlDecode for the instruction in decode
   typedef struct packed {
      logic isBranch;     // Conditional branch family 011xx
      logic isJump;       // Unconditional jump family 001xx
      logic isJumpLink;   // The two linking jumps write the return address
      logic isHalt;
      logic isLbi;
   } ctrlT;

   // Register write request coming back from the writeback stage
   typedef struct packed {
      logic                    en;     // Writeback wants a register write
      logic [regAddrWidth-1:0] addr;
      logic [dataWidth-1:0]    data;   // ALU or load result
      logic [dataWidth-1:0]    imm;    // Immediate for lbi
      logic                    lbi;    // Take imm instead of data
   } wbPortT;

endpackage

//--- controlDecode.sv
// Main control decoder for the instruction sitting in decode
// Maps the five-bit opcode onto the ctrlT bundle used by the rest of the pipeline
`timescale 1ns/1ps

module controlDecode (
   input  logic [decodePkg::dataWidth-1:0] instr,
   output decodePkg::ctrlT                 ctrl
);
   import decodePkg::*;

   logic [opWidth-1:0] opcode;

   assign opcode = instr[dataWidth-1 -: opWidth];   // Top five bits carry the opcode

   always_comb begin
      // Everything defaults to an ordinary ALU or memory instruction
      ctrl = '0;

      case (opcode)
         opHalt: begin
            ctrl.isHalt = 1'b1;   // Stops the machine and suppresses any redirect
         end

         // Plain jumps redirect unconditionally
         opJ: begin
            ctrl.isJump = 1'b1;
         end
         opJr: begin
            ctrl.isJump = 1'b1;
         end

         // Linking jumps also write the return address into the link register
         opJal: begin
            ctrl.isJump     = 1'b1;
            ctrl.isJumpLink = 1'b1;
         end
         opJalr: begin
            ctrl.isJump     = 1'b1;
            ctrl.isJumpLink = 1'b1;
         end

         // Conditional branches, the condition itself is resolved later
         opBeqz: begin
            ctrl.isBranch = 1'b1;   // Taken when Rs is zero
         end
         opBnez: begin
            ctrl.isBranch = 1'b1;   // Taken when Rs is nonzero
         end
         opBltz: begin
            ctrl.isBranch = 1'b1;   // Taken when Rs is negative
         end
         opBgez: begin
            ctrl.isBranch = 1'b1;   // Taken when Rs is zero or positive
         end

         opLbi: begin
            ctrl.isLbi = 1'b1;      // Writeback takes the immediate
         end

         default: begin
            ctrl = '0;              // Other opcodes need nothing from decode control
         end
      endcase
   end

   // The branch and jump families share no opcode, so the redirect logic
   // never sees both flags at once
   always_comb begin
      assert (!(ctrl.isBranch && ctrl.isJump))
         else $error("controlDecode: branch and jump both set for opcode %b", opcode);
   end

endmodule

//--- registerFile.sv
// Eight-entry general register file with two combinational read ports
// The single write port lands on the rising edge and is bypassed to same-cycle reads
`timescale 1ns/1ps

module registerFile (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [decodePkg::regAddrWidth-1:0] readAddr1,
   input  logic [decodePkg::regAddrWidth-1:0] readAddr2,
   input  logic [decodePkg::regAddrWidth-1:0] writeAddr,
   input  logic [decodePkg::dataWidth-1:0]    writeData,
   input  logic                               writeEn,
   output logic [decodePkg::dataWidth-1:0]    readData1,
   output logic [decodePkg::dataWidth-1:0]    readData2
);
   import decodePkg::*;

   logic [dataWidth-1:0] regs [numRegs];
   logic                 hit1;
   logic                 hit2;

   // Storage, every register comes out of reset as zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   // A write to the address being read this cycle is forwarded straight through,
   // so decode sees the value writeback is committing
   assign hit1 = writeEn && (writeAddr == readAddr1);
   assign hit2 = writeEn && (writeAddr == readAddr2);

   assign readData1 = hit1 ? writeData : regs[readAddr1];   // Rs port
   assign readData2 = hit2 ? writeData : regs[readAddr2];   // Rt port

   // An unknown write address would corrupt an arbitrary register
   property writeAddrKnown;
      @(posedge clk) disable iff (reset)
         writeEn |-> !$isunknown(writeAddr);
   endproperty

   assert property (writeAddrKnown)
      else $error("registerFile: write enabled with unknown address");

endmodule

//--- branchResolve.sv
// Branch and jump resolution for the instruction in decode
// Tests Rs against the selected condition and raises pcSel when the PC must redirect
`timescale 1ns/1ps

module branchResolve (
   input  decodePkg::ctrlT                 ctrl,
   input  logic [1:0]                      cond,
   input  logic [decodePkg::dataWidth-1:0] rsValue,
   output logic                            pcSel
);
   import decodePkg::*;

   logic isZero;
   logic isNeg;
   logic condMet;

   assign isZero = (rsValue == '0);            // Equal to zero
   assign isNeg  = rsValue[dataWidth-1];       // Sign bit of the two's complement value

   // The low opcode bits select which test the branch applies
   always_comb begin
      case (cond)
         opBeqz[1:0]: condMet = isZero;
         opBnez[1:0]: condMet = !isZero;
         opBltz[1:0]: condMet = isNeg;
         opBgez[1:0]: condMet = !isNeg;         // Zero counts as non-negative
         default:     condMet = 1'b0;
      endcase
   end

   // Jumps always redirect and branches redirect only when taken.
   // A halt holds the PC where it is no matter what else is set
   assign pcSel = !ctrl.isHalt && (ctrl.isJump || (ctrl.isBranch && condMet));

   // A halt arriving together with a redirecting family means the decoder is broken
   always_comb begin
      assert (!(ctrl.isHalt && (ctrl.isJump || ctrl.isBranch)))
         else $error("branchResolve: halt arrived together with a jump or branch flag");
   end

endmodule

//--- decodeStage.sv
// Decode stage datapath around the register file and branch resolver
// Chooses between link writes and writeback writes and tracks jal through the pipe
`timescale 1ns/1ps

module decodeStage (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [decodePkg::dataWidth-1:0] instr,
   input  logic [decodePkg::dataWidth-1:0] pcNow,
   input  decodePkg::ctrlT                 ctrl,
   input  decodePkg::wbPortT               wb,
   output logic [decodePkg::dataWidth-1:0] reg1Data,
   output logic [decodePkg::dataWidth-1:0] reg2Data,
   output logic                            pcSel
);
   import decodePkg::*;

   logic [regAddrWidth-1:0] rsAddr;
   logic [regAddrWidth-1:0] rtAddr;
   logic [regAddrWidth-1:0] writeAddr;
   logic [dataWidth-1:0]    writeData;
   logic [dataWidth-1:0]    returnAddr;
   logic [dataWidth-1:0]    wbValue;
   logic                    writeEn;
   logic                    wbWriteOk;

   // Jump-link markers for the execute, memory and writeback positions
   logic exJumpLink;
   logic memJumpLink;
   logic wbJumpLink;

   // Source register fields
   assign rsAddr = instr[10:8];
   assign rtAddr = instr[7:5];

   assign returnAddr = pcNow + instrBytes;            // Address of the instruction after jal
   assign wbValue    = wb.lbi ? wb.imm : wb.data;     // lbi carries its result as an immediate

   // The linking jump already wrote its return address from decode, so when it
   // reaches writeback its own write request must be dropped
   assign wbWriteOk = wb.en && !wbJumpLink;

   // Write priority
   // A jump-and-link in decode wins and writes the link register at once.
   // Otherwise the writeback request goes through if it is not a stale jal
   always_comb begin
      if (ctrl.isJumpLink) begin
         writeAddr = linkReg;
         writeData = returnAddr;
      end else begin
         writeAddr = wb.addr;
         writeData = wbValue;
      end
   end

   assign writeEn = ctrl.isJumpLink || wbWriteOk;

   // Three-deep shift chain that follows the jal down to writeback
   always_ff @(posedge clk) begin
      if (reset) begin
         exJumpLink  <= 1'b0;
         memJumpLink <= 1'b0;
         wbJumpLink  <= 1'b0;
      end else begin
         exJumpLink  <= ctrl.isJumpLink;   // Enters execute next cycle
         memJumpLink <= exJumpLink;
         wbJumpLink  <= memJumpLink;       // Blocks the writeback write three cycles on
      end
   end

   registerFile i_registerFile (
      .clk       (clk),
      .reset     (reset),
      .readAddr1 (rsAddr),
      .readAddr2 (rtAddr),
      .writeAddr (writeAddr),
      .writeData (writeData),
      .writeEn   (writeEn),
      .readData1 (reg1Data),
      .readData2 (reg2Data)
   );

   // Conditions are tested on Rs, the first read port
   branchResolve i_branchResolve (
      .ctrl    (ctrl),
      .cond    (instr[12:11]),
      .rsValue (reg1Data),
      .pcSel   (pcSel)
   );

endmodule

//--- decodeTop.sv
// Top of the decode subsystem
// Joins the control decoder to the decode datapath and exports the control bundle
`timescale 1ns/1ps

module decodeTop (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [decodePkg::dataWidth-1:0] instr,
   input  logic [decodePkg::dataWidth-1:0] pcNow,
   input  decodePkg::wbPortT               wb,
   output logic [decodePkg::dataWidth-1:0] reg1Data,
   output logic [decodePkg::dataWidth-1:0] reg2Data,
   output logic                            pcSel,
   output decodePkg::ctrlT                 ctrl
);
   import decodePkg::*;

   // Control flows combinationally into the datapath and on to later stages
   controlDecode i_controlDecode (
      .instr (instr),
      .ctrl  (ctrl)
   );

   decodeStage i_decodeStage (
      .clk      (clk),
      .reset    (reset),
      .instr    (instr),
      .pcNow    (pcNow),
      .ctrl     (ctrl),
      .wb       (wb),
      .reg1Data (reg1Data),
      .reg2Data (reg2Data),
      .pcSel    (pcSel)     // Redirect strobe for fetch
   );

endmodule

//--- decodeTb.sv
// Self-checking testbench for the decode subsystem
// A shadow register file and jal chain predict reg1Data, reg2Data, pcSel and ctrl every cycle
`timescale 1ns/1ps

module decodeTb;
   import decodePkg::*;

   localparam int clkPeriod    = 4;
   localparam int stimCycles   = 184;   // Reset plus all five test sequences
   localparam int marginCycles = 50;
   localparam logic [4:0] opAlu = 5'b11011;   // Any opcode that needs no decode control

   // Write that the current inputs put in front of the register file
   typedef struct packed {
      logic                    en;
      logic [regAddrWidth-1:0] addr;
      logic [dataWidth-1:0]    data;
   } writeT;

   // Outputs the reference predicts for one cycle
   typedef struct packed {
      logic [dataWidth-1:0] r1;
      logic [dataWidth-1:0] r2;
      logic                 pcSel;
      ctrlT                 ctrl;
   } expT;

   logic                 clk;
   logic                 reset;
   logic [dataWidth-1:0] instr;
   logic [dataWidth-1:0] pcNow;
   wbPortT               wb;
   logic [dataWidth-1:0] reg1Data;
   logic [dataWidth-1:0] reg2Data;
   logic                 pcSel;
   ctrlT                 ctrl;

   logic [dataWidth-1:0] shadowRegs [numRegs];
   logic [2:0]           shadowLink;   // Bit 0 execute, bit 1 memory, bit 2 writeback
   logic                 checking;
   string                testName;
   int                   errors;
   int                   checkCount;
   int                   seed;
   logic [31:0]          rnd;

   decodeTop i_decodeTop (
      .clk      (clk),
      .reset    (reset),
      .instr    (instr),
      .pcNow    (pcNow),
      .wb       (wb),
      .reg1Data (reg1Data),
      .reg2Data (reg2Data),
      .pcSel    (pcSel),
      .ctrl     (ctrl)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Instruction word with the opcode and the two source fields filled in
   function automatic logic [dataWidth-1:0] makeInstr(input logic [4:0] op,
                                                       input logic [2:0] rs,
                                                       input logic [2:0] rt);
      return {op, rs, rt, 5'b00000};
   endfunction

   function automatic wbPortT makeWb(input logic en, input logic [2:0] addr,
                                     input logic [15:0] data, input logic [15:0] imm,
                                     input logic lbi);
      wbPortT w;
      w.en   = en;
      w.addr = addr;
      w.data = data;
      w.imm  = imm;
      w.lbi  = lbi;
      return w;
   endfunction

   // A linking jump in decode wins over writeback, which is dropped while a jal sits in writeback
   function automatic writeT pendingWrite();
      writeT w;
      w = '0;
      if (instr[15:12] == 4'b0011) begin
         w.en   = 1'b1;
         w.addr = linkReg;
         w.data = pcNow + 16'd2;   // Return address
      end else if (wb.en && !shadowLink[2]) begin
         w.en   = 1'b1;
         w.addr = wb.addr;
         w.data = wb.lbi ? wb.imm : wb.data;
      end
      return w;
   endfunction

   // Reference for the decode outputs from shadow state, instr and the write in flight
   function automatic expT expectedOutputs(input writeT w);
      expT         e;
      logic [4:0]  op;
      logic [15:0] rs;
      logic        taken;
      op   = instr[15:11];
      e.r1 = (w.en && w.addr == instr[10:8]) ? w.data : shadowRegs[instr[10:8]];
      e.r2 = (w.en && w.addr == instr[7:5]) ? w.data : shadowRegs[instr[7:5]];
      rs   = e.r1;
      case (op[1:0])
         2'b00:   taken = (rs == 16'd0);    // beqz
         2'b01:   taken = (rs != 16'd0);    // bnez
         2'b10:   taken = rs[15];           // bltz
         default: taken = !rs[15];          // bgez
      endcase
      e.pcSel = (op != 5'b00000) && ((op[4:2] == 3'b001) || (op[4:2] == 3'b011 && taken));
      // Control flags straight from the opcode families
      e.ctrl.isBranch   = (op[4:2] == 3'b011);
      e.ctrl.isJump     = (op[4:2] == 3'b001);
      e.ctrl.isJumpLink = (op[4:1] == 4'b0011);   // jal and jalr
      e.ctrl.isHalt     = (op == 5'b00000);
      e.ctrl.isLbi      = (op == 5'b11000);
      return e;
   endfunction

   // Shadow state follows the DUT at every rising edge
   always @(posedge clk) begin
      writeT w;
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            shadowRegs[i] = '0;
         end
         shadowLink = '0;
      end else begin
         w = pendingWrite();
         if (w.en) begin
            shadowRegs[w.addr] = w.data;
         end
         shadowLink = {shadowLink[1:0], instr[15:12] == 4'b0011};
      end
   end

   // Compare 1 ns before the next rising edge when all outputs have settled
   initial begin
      expT want;
      forever begin
         @(posedge clk);
         #(clkPeriod - 1);
         if (checking) begin
            want = expectedOutputs(pendingWrite());
            checkCount++;
            if (reg1Data !== want.r1) begin
               errors++;
               $display("** Error [%s] reg1Data expected %h actual %h", testName, want.r1,
                        reg1Data);
            end
            if (reg2Data !== want.r2) begin
               errors++;
               $display("** Error [%s] reg2Data expected %h actual %h", testName, want.r2,
                        reg2Data);
            end
            if (pcSel !== want.pcSel) begin
               errors++;
               $display("** Error [%s] pcSel expected %b actual %b", testName, want.pcSel,
                        pcSel);
            end
            if (ctrl !== want.ctrl) begin
               errors++;
               $display("** Error [%s] ctrl expected %b actual %b", testName, want.ctrl,
                        ctrl);
            end
         end
      end
   end

   // Ends a run that never reaches its summary
   initial begin
      #((stimCycles + marginCycles) * clkPeriod);
      $display("Timeout: the stimulus did not finish within %0d cycles",
               stimCycles + marginCycles);
      $display("=== FAIL ===");
      $finish;
   end

   // Inputs change 1 ns after the rising edge
   task automatic driveCycle(input logic [15:0] ins, input logic [15:0] pc, input wbPortT w);
      @(posedge clk);
      #1;
      instr = ins;
      pcNow = pc;
      wb    = w;
   endtask

   task automatic randomWord(output logic [15:0] v);
      rnd = $random(seed);
      v   = rnd[15:0];
   endtask

   task automatic randomWb(output wbPortT w);
      logic [15:0] d;
      logic [15:0] i;
      randomWord(d);
      randomWord(i);
      rnd = $random(seed);
      w   = makeWb(rnd[0] | rnd[1], rnd[4:2], d, i, rnd[5]);   // Three writes in four
   endtask

   initial begin
      logic [15:0] vals [5];
      logic [15:0] pc;
      logic [15:0] data;
      logic [15:0] linkVal;
      logic [15:0] wantR1;
      wbPortT      w;
      wbPortT      noWb;
      clk        = 1'b0;
      reset      = 1'b1;
      instr      = '0;
      pcNow      = '0;
      wb         = '0;
      noWb       = '0;
      checking   = 1'b0;
      errors     = 0;
      checkCount = 0;
      seed       = 19;
      testName   = "reset";
      vals       = '{16'h0000, 16'h1234, 16'h8001, 16'h7fff, 16'hffff};
      repeat (3) @(posedge clk);
      #1;
      reset    = 1'b0;
      checking = 1'b1;

      // Every register reads zero before random writebacks land and read back
      for (int a = 0; a < numRegs; a++) begin
         driveCycle(makeInstr(opAlu, 3'(a), 3'(7 - a)), 16'h0, noWb);
      end
      testName = "randomWrites";
      for (int n = 0; n < 40; n++) begin
         randomWb(w);
         randomWord(pc);
         driveCycle(makeInstr(opAlu, pc[2:0], pc[5:3]), pc, w);
      end
      for (int a = 0; a < numRegs; a++) begin
         driveCycle(makeInstr(opAlu, 3'(a), 3'(a)), 16'h0, noWb);
      end

      // Same-address read and write in one cycle with plain data and then lbi immediates
      testName = "writeThrough";
      for (int a = 0; a < numRegs; a++) begin
         randomWord(data);
         driveCycle(makeInstr(opAlu, 3'(a), 3'(a)), 16'h0, makeWb(1'b1, 3'(a), data, 16'h0,
                    1'b0));
      end
      for (int a = 0; a < numRegs; a++) begin
         randomWord(data);
         randomWord(pc);
         driveCycle(makeInstr(opLbi, 3'(a), 3'(a)), 16'h0, makeWb(1'b1, 3'(a), pc, data, 1'b1));
      end
      for (int a = 0; a < numRegs; a++) begin
         driveCycle(makeInstr(opAlu, 3'(a), 3'(a + 1)), 16'h0, noWb);
      end

      // Each condition against zero, positive and negative values in r3
      testName = "branch";
      for (int c = 0; c < 4; c++) begin
         for (int v = 0; v < 5; v++) begin
            driveCycle(makeInstr(opAlu, 3'd3, 3'd0), 16'h0, makeWb(1'b1, 3'd3, vals[v], 16'h0,
                       1'b0));
            driveCycle(makeInstr({3'b011, 2'(c)}, 3'd3, 3'd0), 16'h40, noWb);
         end
      end
      for (int n = 0; n < 20; n++) begin
         randomWb(w);
         rnd = $random(seed);
         driveCycle(makeInstr({3'b011, rnd[1:0]}, rnd[4:2], rnd[7:5]), 16'h80, w);
      end

      // Every jump redirects while a halt never does
      testName = "jumpHalt";
      for (int n = 0; n < 12; n++) begin
         randomWb(w);
         randomWord(pc);
         rnd = $random(seed);
         driveCycle(makeInstr({3'b001, rnd[1:0]}, rnd[4:2], rnd[7:5]), pc, w);
      end
      for (int n = 0; n < 6; n++) begin
         rnd = $random(seed);
         driveCycle(makeInstr(opHalt, rnd[2:0], rnd[5:3]), 16'h0, noWb);
      end

      // A jal beats a pending writeback and its own stale writeback slot is dropped
      testName = "jumpLink";
      repeat (3) driveCycle(makeInstr(opAlu, 3'd0, 3'd0), 16'h0, noWb);
      for (int d = 2; d <= 4; d++) begin
         driveCycle(makeInstr(opAlu, 3'd1, 3'd0), 16'h0, makeWb(1'b1, 3'd1, 16'h1111, 16'h0,
                    1'b0));
         randomWord(pc);
         linkVal = pc + 16'd2;
         driveCycle(makeInstr(opJal, 3'd7, 3'd1), pc, makeWb(1'b1, 3'd7, 16'hdead, 16'h0,
                    1'b0));
         #2;
         checkCount++;
         if (reg1Data !== linkVal) begin
            errors++;
            $display("** Error [%s] link write expected %h actual %h", testName, linkVal,
                     reg1Data);
         end
         repeat (d - 1) driveCycle(makeInstr(opAlu, 3'd1, 3'd7), 16'h0, noWb);
         randomWord(data);
         driveCycle(makeInstr(opAlu, 3'd2, 3'd0), 16'h0, makeWb(1'b1, 3'd1, data, 16'h0, 1'b0));
         driveCycle(makeInstr(opAlu, 3'd1, 3'd7), 16'h0, noWb);
         #2;
         wantR1 = (d == 3) ? 16'h1111 : data;   // Only the slot three cycles on is blocked
         checkCount++;
         if (reg1Data !== wantR1) begin
            errors++;
            $display("** Error [%s] r1 after %0d cycles expected %h actual %h", testName, d,
                     wantR1, reg1Data);
         end
         if (reg2Data !== linkVal) begin
            errors++;
            $display("** Error [%s] r7 expected %h actual %h", testName, linkVal, reg2Data);
         end
      end

      driveCycle(makeInstr(opAlu, 3'd0, 3'd0), 16'h0, noWb);
      @(posedge clk);
      #2;
      $display("Checks run %0d, errors %0d", checkCount, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- files.f
decodePkg.sv
controlDecode.sv
registerFile.sv
branchResolve.sv
decodeStage.sv
decodeTop.sv
decodeTb.sv

//--- run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
# The run fails on a build error, a simulator error or a fail message in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module decodeTb -Mdir obj_dir \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VdecodeTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
   exit 1
fi

exit 0
